/* rtl/mipsCtrlPkg.sv */
`default_nettype none

package mipsCtrlPkg;

  // Instruction field positions
  localparam int OPCODE_MSB = 31;
  localparam int OPCODE_LSB = 26;
  localparam int RT_MSB = 20;
  localparam int RT_LSB = 16;
  localparam int FUNCT_MSB = 5;
  localparam int FUNCT_LSB = 0;

  // REGIMM branches are told apart by the rt field
  localparam logic [4:0] RT_BLTZ = 5'b00000;
  localparam logic [4:0] RT_BGEZ = 5'b00001;

  typedef enum logic [5:0] {
    OP_RTYPE  = 6'b000000,
    OP_REGIMM = 6'b000001,
    OP_J      = 6'b000010,
    OP_BEQ    = 6'b000100,
    OP_BNE    = 6'b000101,
    OP_BLEZ   = 6'b000110,
    OP_BGTZ   = 6'b000111,
    OP_ADDIU  = 6'b001001,
    OP_SLTI   = 6'b001010,
    OP_ANDI   = 6'b001100,
    OP_ORI    = 6'b001101,
    OP_XORI   = 6'b001110,
    OP_LUI    = 6'b001111,
    OP_LB     = 6'b100000,
    OP_LH     = 6'b100001,
    OP_LW     = 6'b100011,
    OP_LBU    = 6'b100100,
    OP_LHU    = 6'b100101,
    OP_SW     = 6'b101011
  } opcode_t;

  typedef enum logic [5:0] {
    FN_JR   = 6'b001000,
    FN_ADDU = 6'b100001,
    FN_AND  = 6'b100100,
    FN_OR   = 6'b100101
  } funct_t;

  typedef enum logic [2:0] {
    ST_FETCH  = 3'd0,
    ST_DECODE = 3'd1,
    ST_EXEC1  = 3'd2,
    ST_EXEC2  = 3'd3,
    ST_EXEC3  = 3'd4,
    ST_HALTED = 3'd5,
    ST_STALL  = 3'd6
  } ctrlState_t;

  // Encodings shared with the datapath ALU
  typedef enum logic [4:0] {
    ALU_AND      = 5'b00000,
    ALU_OR       = 5'b00001,
    ALU_ADD      = 5'b00010,
    ALU_XOR      = 5'b00011,
    ALU_SLT      = 5'b00111,
    ALU_CMPEQ    = 5'b01010,
    ALU_PASSB    = 5'b01011,
    ALU_CMPZ     = 5'b01100,
    ALU_BRTARGET = 5'b01101,
    ALU_PASSA    = 5'b01110,
    ALU_FUNCT    = 5'b01111,
    ALU_JTARGET  = 5'b10001,
    ALU_LUI      = 5'b10100
  } aluOp_t;

  typedef enum logic [1:0] {
    MEM_WORD,
    MEM_HALF,
    MEM_BYTE
  } memSize_t;

  typedef enum logic [2:0] {
    CLS_ALUREG,
    CLS_ALUIMM,
    CLS_LOAD,
    CLS_STORE,
    CLS_BRANCH,
    CLS_JUMP,
    CLS_JUMPREG,
    CLS_INVALID
  } instrClass_t;

  typedef enum logic [2:0] {
    BR_EQ,
    BR_NE,
    BR_LEZ,
    BR_GTZ,
    BR_LTZ,
    BR_GEZ
  } branchCond_t;

endpackage

`default_nettype wire

/* rtl/decodedIf.sv */
`default_nettype none

// Decoded view of the held instruction word
interface decodedIf;

  mipsCtrlPkg::instrClass_t instrClass;
  mipsCtrlPkg::aluOp_t aluOp;
  mipsCtrlPkg::memSize_t memSize;
  logic signedLoad;
  mipsCtrlPkg::branchCond_t branchCond;

  modport producer (
    output instrClass, aluOp, memSize, signedLoad, branchCond
  );

  modport sequencer (
    input instrClass, branchCond
  );

  modport stepper (
    input instrClass, aluOp, memSize, signedLoad, branchCond
  );

endinterface

`default_nettype wire

/* rtl/instrClassifier.sv */
`default_nettype none

module instrClassifier (
  input  logic [31:0]       instr,
  decodedIf.producer        dec
);

  mipsCtrlPkg::opcode_t opcode;
  mipsCtrlPkg::funct_t funct;
  logic [4:0] rtField;

  assign opcode = mipsCtrlPkg::opcode_t'(
    instr[mipsCtrlPkg::OPCODE_MSB:mipsCtrlPkg::OPCODE_LSB]);
  assign funct = mipsCtrlPkg::funct_t'(
    instr[mipsCtrlPkg::FUNCT_MSB:mipsCtrlPkg::FUNCT_LSB]);
  assign rtField = instr[mipsCtrlPkg::RT_MSB:mipsCtrlPkg::RT_LSB];

  always_comb begin
    dec.instrClass = mipsCtrlPkg::CLS_INVALID;
    dec.aluOp = mipsCtrlPkg::ALU_ADD;
    dec.memSize = mipsCtrlPkg::MEM_WORD;
    dec.signedLoad = 1'b0;
    dec.branchCond = mipsCtrlPkg::BR_EQ;

    case (opcode)
      mipsCtrlPkg::OP_RTYPE: begin
        case (funct)
          mipsCtrlPkg::FN_ADDU, mipsCtrlPkg::FN_AND, mipsCtrlPkg::FN_OR: begin
            // ALU picks the operation from funct itself
            dec.instrClass = mipsCtrlPkg::CLS_ALUREG;
            dec.aluOp = mipsCtrlPkg::ALU_FUNCT;
          end
          mipsCtrlPkg::FN_JR: begin
            dec.instrClass = mipsCtrlPkg::CLS_JUMPREG;
            dec.aluOp = mipsCtrlPkg::ALU_PASSA;
          end
          default: ;
        endcase
      end
      mipsCtrlPkg::OP_REGIMM: begin
        if (rtField == mipsCtrlPkg::RT_BLTZ) begin
          dec.instrClass = mipsCtrlPkg::CLS_BRANCH;
          dec.aluOp = mipsCtrlPkg::ALU_CMPZ;
          dec.branchCond = mipsCtrlPkg::BR_LTZ;
        end else if (rtField == mipsCtrlPkg::RT_BGEZ) begin
          dec.instrClass = mipsCtrlPkg::CLS_BRANCH;
          dec.aluOp = mipsCtrlPkg::ALU_CMPZ;
          dec.branchCond = mipsCtrlPkg::BR_GEZ;
        end
      end
      mipsCtrlPkg::OP_J: begin
        dec.instrClass = mipsCtrlPkg::CLS_JUMP;
        dec.aluOp = mipsCtrlPkg::ALU_JTARGET;
      end
      mipsCtrlPkg::OP_BEQ, mipsCtrlPkg::OP_BNE: begin
        dec.instrClass = mipsCtrlPkg::CLS_BRANCH;
        dec.aluOp = mipsCtrlPkg::ALU_CMPEQ;
        dec.branchCond = (opcode == mipsCtrlPkg::OP_BEQ) ?
                         mipsCtrlPkg::BR_EQ : mipsCtrlPkg::BR_NE;
      end
      mipsCtrlPkg::OP_BLEZ, mipsCtrlPkg::OP_BGTZ: begin
        dec.instrClass = mipsCtrlPkg::CLS_BRANCH;
        dec.aluOp = mipsCtrlPkg::ALU_CMPZ;
        dec.branchCond = (opcode == mipsCtrlPkg::OP_BLEZ) ?
                         mipsCtrlPkg::BR_LEZ : mipsCtrlPkg::BR_GTZ;
      end
      mipsCtrlPkg::OP_ADDIU: begin
        dec.instrClass = mipsCtrlPkg::CLS_ALUIMM;
        dec.aluOp = mipsCtrlPkg::ALU_ADD;
      end
      mipsCtrlPkg::OP_SLTI: begin
        dec.instrClass = mipsCtrlPkg::CLS_ALUIMM;
        dec.aluOp = mipsCtrlPkg::ALU_SLT;
      end
      mipsCtrlPkg::OP_ANDI: begin
        dec.instrClass = mipsCtrlPkg::CLS_ALUIMM;
        dec.aluOp = mipsCtrlPkg::ALU_AND;
      end
      mipsCtrlPkg::OP_ORI: begin
        dec.instrClass = mipsCtrlPkg::CLS_ALUIMM;
        dec.aluOp = mipsCtrlPkg::ALU_OR;
      end
      mipsCtrlPkg::OP_XORI: begin
        dec.instrClass = mipsCtrlPkg::CLS_ALUIMM;
        dec.aluOp = mipsCtrlPkg::ALU_XOR;
      end
      mipsCtrlPkg::OP_LUI: begin
        dec.instrClass = mipsCtrlPkg::CLS_ALUIMM;
        dec.aluOp = mipsCtrlPkg::ALU_LUI;
      end
      // Loads and the store compute base plus offset
      mipsCtrlPkg::OP_LW, mipsCtrlPkg::OP_LH, mipsCtrlPkg::OP_LHU,
      mipsCtrlPkg::OP_LB, mipsCtrlPkg::OP_LBU: begin
        dec.instrClass = mipsCtrlPkg::CLS_LOAD;
        dec.signedLoad = (opcode == mipsCtrlPkg::OP_LH) || (opcode == mipsCtrlPkg::OP_LB);
        if ((opcode == mipsCtrlPkg::OP_LH) || (opcode == mipsCtrlPkg::OP_LHU)) begin
          dec.memSize = mipsCtrlPkg::MEM_HALF;
        end else if ((opcode == mipsCtrlPkg::OP_LB) || (opcode == mipsCtrlPkg::OP_LBU)) begin
          dec.memSize = mipsCtrlPkg::MEM_BYTE;
        end
      end
      mipsCtrlPkg::OP_SW: begin
        dec.instrClass = mipsCtrlPkg::CLS_STORE;
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

/* rtl/stateSequencer.sv */
`default_nettype none

module stateSequencer (
  input  logic                    clk,
  input  logic                    rstN,
  input  logic                    stall,
  input  logic                    waitrequest,
  input  logic                    pcIsZero,
  input  logic                    start,
  input  logic                    aluFlag,
  input  logic                    lessThan,
  decodedIf.sequencer             dec,
  output mipsCtrlPkg::ctrlState_t state,
  output logic                    branchPending
);

  mipsCtrlPkg::ctrlState_t nextState;
  logic needsExec2;
  logic redirects;
  logic branchTaken;

  assign needsExec2 = (dec.instrClass == mipsCtrlPkg::CLS_ALUREG) ||
                      (dec.instrClass == mipsCtrlPkg::CLS_ALUIMM) ||
                      (dec.instrClass == mipsCtrlPkg::CLS_LOAD) ||
                      (dec.instrClass == mipsCtrlPkg::CLS_STORE);

  assign redirects = (dec.instrClass == mipsCtrlPkg::CLS_BRANCH) ||
                     (dec.instrClass == mipsCtrlPkg::CLS_JUMP) ||
                     (dec.instrClass == mipsCtrlPkg::CLS_JUMPREG);

  always_comb begin
    case (dec.branchCond)
      mipsCtrlPkg::BR_EQ:  branchTaken = aluFlag;
      mipsCtrlPkg::BR_NE:  branchTaken = !aluFlag;
      mipsCtrlPkg::BR_LEZ: branchTaken = aluFlag;
      mipsCtrlPkg::BR_GTZ: branchTaken = !aluFlag;
      mipsCtrlPkg::BR_LTZ: branchTaken = lessThan;
      mipsCtrlPkg::BR_GEZ: branchTaken = !lessThan;
      default:             branchTaken = 1'b0;
    endcase
    // Jumps always redirect
    if (dec.instrClass != mipsCtrlPkg::CLS_BRANCH) begin
      branchTaken = 1'b1;
    end
  end

  always_comb begin
    nextState = state;
    case (state)
      mipsCtrlPkg::ST_FETCH,
      mipsCtrlPkg::ST_STALL:  nextState = waitrequest ? mipsCtrlPkg::ST_STALL :
                                                        mipsCtrlPkg::ST_DECODE;
      mipsCtrlPkg::ST_DECODE: nextState = mipsCtrlPkg::ST_EXEC1;
      mipsCtrlPkg::ST_EXEC1: begin
        if (!stall) begin
          nextState = needsExec2 ? mipsCtrlPkg::ST_EXEC2 : mipsCtrlPkg::ST_FETCH;
        end
      end
      mipsCtrlPkg::ST_EXEC2: begin
        if (!waitrequest) begin
          nextState = (dec.instrClass == mipsCtrlPkg::CLS_LOAD) ?
                      mipsCtrlPkg::ST_EXEC3 : mipsCtrlPkg::ST_FETCH;
        end
      end
      mipsCtrlPkg::ST_EXEC3:  nextState = mipsCtrlPkg::ST_FETCH;
      mipsCtrlPkg::ST_HALTED: nextState = start ? mipsCtrlPkg::ST_FETCH :
                                                  mipsCtrlPkg::ST_HALTED;
      default:                nextState = mipsCtrlPkg::ST_HALTED;
    endcase
    // PC of zero stops the core from any running state
    if (pcIsZero && (state != mipsCtrlPkg::ST_HALTED)) begin
      nextState = mipsCtrlPkg::ST_HALTED;
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state <= mipsCtrlPkg::ST_HALTED;
      branchPending <= 1'b0;
    end else begin
      state <= nextState;
      if ((state == mipsCtrlPkg::ST_EXEC1) && (nextState != mipsCtrlPkg::ST_EXEC1) &&
          redirects) begin
        branchPending <= branchTaken;
      end else if (((state == mipsCtrlPkg::ST_FETCH) || (state == mipsCtrlPkg::ST_STALL)) &&
                   (nextState == mipsCtrlPkg::ST_DECODE)) begin
        branchPending <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/stepControl.sv */
`default_nettype none

module stepControl (
  input  mipsCtrlPkg::ctrlState_t state,
  input  logic                    branchPending,
  decodedIf.stepper               dec,
  output logic                    pcWrite,
  output logic                    irWrite,
  output logic                    regWrite,
  output logic                    memRead,
  output logic                    memWrite,
  output logic                    irSel,
  output logic                    iOrD,
  output logic                    pcSrc,
  output logic                    aluSrcA,
  output logic                    aluSel,
  output logic                    regDst,
  output logic                    memToReg,
  output logic                    extSel,
  output logic [1:0]              aluSrcB,
  output mipsCtrlPkg::aluOp_t     aluControl,
  output logic [3:0]              byteEnable,
  output logic [1:0]              extendMode,
  output logic                    isJump,
  output logic                    active
);

  logic [3:0] sizeEnable;
  logic [1:0] loadExtend;
  logic logicalImm;

  always_comb begin
    case (dec.memSize)
      mipsCtrlPkg::MEM_HALF: sizeEnable = 4'b0011;
      mipsCtrlPkg::MEM_BYTE: sizeEnable = 4'b0001;
      default:               sizeEnable = 4'b1111;
    endcase
  end

  // 11 sign-extends a half, 10 a byte
  assign loadExtend = !dec.signedLoad ? 2'b00 :
                      (dec.memSize == mipsCtrlPkg::MEM_HALF) ? 2'b11 :
                      (dec.memSize == mipsCtrlPkg::MEM_BYTE) ? 2'b10 : 2'b00;

  // Logical immediates are zero-extended
  assign logicalImm = (dec.instrClass == mipsCtrlPkg::CLS_ALUIMM) &&
                      ((dec.aluOp == mipsCtrlPkg::ALU_AND) ||
                       (dec.aluOp == mipsCtrlPkg::ALU_OR) ||
                       (dec.aluOp == mipsCtrlPkg::ALU_XOR));

  assign active = (state != mipsCtrlPkg::ST_HALTED);

  always_comb begin
    pcWrite = 1'b0;
    irWrite = 1'b0;
    regWrite = 1'b0;
    memRead = 1'b0;
    memWrite = 1'b0;
    irSel = 1'b1;
    iOrD = 1'b0;
    pcSrc = 1'b0;
    aluSrcA = 1'b0;
    aluSel = 1'b0;
    regDst = 1'b0;
    memToReg = 1'b0;
    extSel = 1'b0;
    aluSrcB = 2'b00;
    aluControl = mipsCtrlPkg::ALU_ADD;
    byteEnable = 4'b1111;
    extendMode = 2'b00;
    isJump = 1'b0;

    case (state)
      mipsCtrlPkg::ST_FETCH: begin
        pcWrite = 1'b1;
        memRead = 1'b1;
        if (branchPending) begin
          pcSrc = 1'b1;
        end else begin
          // PC plus 4
          aluSrcB = 2'b01;
        end
      end
      mipsCtrlPkg::ST_STALL: begin
        memRead = 1'b1;
      end
      mipsCtrlPkg::ST_DECODE: begin
        irWrite = 1'b1;
        irSel = 1'b0;
        aluSrcB = 2'b11;
        if (dec.instrClass == mipsCtrlPkg::CLS_JUMP) begin
          extSel = 1'b1;
          aluControl = mipsCtrlPkg::ALU_PASSB;
        end else begin
          aluControl = mipsCtrlPkg::ALU_BRTARGET;
        end
      end
      mipsCtrlPkg::ST_EXEC1: begin
        aluControl = dec.aluOp;
        aluSrcA = 1'b1;
        case (dec.instrClass)
          mipsCtrlPkg::CLS_ALUIMM: begin
            aluSrcB = 2'b10;
            extSel = logicalImm;
          end
          mipsCtrlPkg::CLS_LOAD,
          mipsCtrlPkg::CLS_STORE:  aluSrcB = 2'b10;
          mipsCtrlPkg::CLS_BRANCH: aluSel = 1'b1;
          mipsCtrlPkg::CLS_JUMP: begin
            aluSrcA = 1'b0;
            aluSrcB = 2'b11;
            extSel = 1'b1;
            isJump = 1'b1;
          end
          default: ;
        endcase
      end
      mipsCtrlPkg::ST_EXEC2: begin
        aluSel = 1'b1;
        case (dec.instrClass)
          mipsCtrlPkg::CLS_LOAD: begin
            memRead = 1'b1;
            iOrD = 1'b1;
            byteEnable = sizeEnable;
            extendMode = loadExtend;
          end
          mipsCtrlPkg::CLS_STORE: begin
            memWrite = 1'b1;
            iOrD = 1'b1;
            byteEnable = sizeEnable;
          end
          mipsCtrlPkg::CLS_ALUREG,
          mipsCtrlPkg::CLS_ALUIMM: begin
            regWrite = 1'b1;
            memToReg = 1'b1;
            regDst = (dec.instrClass == mipsCtrlPkg::CLS_ALUREG);
          end
          default: ;
        endcase
      end
      mipsCtrlPkg::ST_EXEC3: begin
        // Write back the loaded data to rt
        regWrite = 1'b1;
        byteEnable = sizeEnable;
        extendMode = loadExtend;
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

/* rtl/controlTop.sv */
`default_nettype none

module controlTop (
  input  logic                    clk,
  input  logic                    rstN,
  input  logic [31:0]             instr,
  input  logic                    stall,
  input  logic                    waitrequest,
  input  logic                    pcIsZero,
  input  logic                    start,
  input  logic                    aluFlag,
  input  logic                    lessThan,
  output mipsCtrlPkg::ctrlState_t state,
  output logic                    branchPending,
  output logic                    active,
  output logic                    pcWrite,
  output logic                    irWrite,
  output logic                    regWrite,
  output logic                    memRead,
  output logic                    memWrite,
  output logic                    irSel,
  output logic                    iOrD,
  output logic                    pcSrc,
  output logic                    aluSrcA,
  output logic                    aluSel,
  output logic                    regDst,
  output logic                    memToReg,
  output logic                    extSel,
  output logic [1:0]              aluSrcB,
  output mipsCtrlPkg::aluOp_t     aluControl,
  output logic [3:0]              byteEnable,
  output logic [1:0]              extendMode,
  output logic                    isJump
);

  decodedIf dec ();

  instrClassifier classifierI (
    .instr (instr),
    .dec   (dec)
  );

  stateSequencer sequencerI (
    .clk           (clk),
    .rstN          (rstN),
    .stall         (stall),
    .waitrequest   (waitrequest),
    .pcIsZero      (pcIsZero),
    .start         (start),
    .aluFlag       (aluFlag),
    .lessThan      (lessThan),
    .dec           (dec),
    .state         (state),
    .branchPending (branchPending)
  );

  stepControl stepI (
    .state         (state),
    .branchPending (branchPending),
    .dec           (dec),
    .pcWrite       (pcWrite),
    .irWrite       (irWrite),
    .regWrite      (regWrite),
    .memRead       (memRead),
    .memWrite      (memWrite),
    .irSel         (irSel),
    .iOrD          (iOrD),
    .pcSrc         (pcSrc),
    .aluSrcA       (aluSrcA),
    .aluSel        (aluSel),
    .regDst        (regDst),
    .memToReg      (memToReg),
    .extSel        (extSel),
    .aluSrcB       (aluSrcB),
    .aluControl    (aluControl),
    .byteEnable    (byteEnable),
    .extendMode    (extendMode),
    .isJump        (isJump),
    .active        (active)
  );

endmodule

`default_nettype wire

/* verif/ctrl_checker.sv */
`default_nettype none

module ctrlChecker (
  input logic                    clk,
  input logic                    rstN,
  input logic [31:0]             instr,
  input logic                    stall,
  input logic                    waitrequest,
  input logic                    pcIsZero,
  input logic                    start,
  input logic                    aluFlag,
  input logic                    lessThan,
  input mipsCtrlPkg::ctrlState_t state,
  input logic                    branchPending,
  input logic                    active,
  input logic                    pcWrite,
  input logic                    irWrite,
  input logic                    regWrite,
  input logic                    memRead,
  input logic                    memWrite,
  input logic                    iOrD,
  input logic                    pcSrc,
  input logic                    regDst,
  input logic                    memToReg,
  input logic                    isJump,
  input logic [1:0]              aluSrcB,
  input mipsCtrlPkg::aluOp_t     aluControl,
  input logic [3:0]              byteEnable,
  input logic [1:0]              extendMode
);

  timeunit 1ns;
  timeprecision 100ps;

  int unsigned failCount = 0;

  logic [5:0] op;
  logic [5:0] fn;
  logic [4:0] rt;
  logic isAluReg;
  logic isAluImm;
  logic isLoad;
  logic isStore;
  logic isBranch;
  logic isJ;
  logic isJr;
  logic known;
  mipsCtrlPkg::aluOp_t expAluOp;
  logic [3:0] expEnable;
  logic [1:0] expExtend;
  logic expTaken;
  mipsCtrlPkg::ctrlState_t expNext;
  mipsCtrlPkg::ctrlState_t prevExpNext;
  logic prevTaken;

  function automatic void reportViolation(string what);
    failCount++;
    $error("%s at %0t", what, $time);
  endfunction

  assign op = instr[31:26];
  assign fn = instr[5:0];
  assign rt = instr[20:16];

  assign isAluReg = (op == mipsCtrlPkg::OP_RTYPE) && (fn inside {mipsCtrlPkg::FN_ADDU,
                    mipsCtrlPkg::FN_AND, mipsCtrlPkg::FN_OR});
  assign isJr = (op == mipsCtrlPkg::OP_RTYPE) && (fn == mipsCtrlPkg::FN_JR);
  assign isJ = (op == mipsCtrlPkg::OP_J);
  assign isAluImm = op inside {mipsCtrlPkg::OP_ADDIU, mipsCtrlPkg::OP_SLTI,
                    mipsCtrlPkg::OP_ANDI, mipsCtrlPkg::OP_ORI, mipsCtrlPkg::OP_XORI,
                    mipsCtrlPkg::OP_LUI};
  assign isLoad = op inside {mipsCtrlPkg::OP_LB, mipsCtrlPkg::OP_LH, mipsCtrlPkg::OP_LW,
                  mipsCtrlPkg::OP_LBU, mipsCtrlPkg::OP_LHU};
  assign isStore = (op == mipsCtrlPkg::OP_SW);
  assign isBranch = (op inside {mipsCtrlPkg::OP_BEQ, mipsCtrlPkg::OP_BNE,
                    mipsCtrlPkg::OP_BLEZ, mipsCtrlPkg::OP_BGTZ}) ||
                    ((op == mipsCtrlPkg::OP_REGIMM) && (rt inside {mipsCtrlPkg::RT_BLTZ,
                    mipsCtrlPkg::RT_BGEZ}));
  assign known = isAluReg || isAluImm || isLoad || isStore || isBranch || isJ || isJr;

  // Reference table per opcode
  always_comb begin
    expAluOp = mipsCtrlPkg::ALU_ADD;
    expEnable = 4'b1111;
    expExtend = 2'b00;
    expTaken = 1'b1;
    case (op)
      mipsCtrlPkg::OP_RTYPE: expAluOp = isJr ? mipsCtrlPkg::ALU_PASSA : mipsCtrlPkg::ALU_FUNCT;
      mipsCtrlPkg::OP_SLTI:  expAluOp = mipsCtrlPkg::ALU_SLT;
      mipsCtrlPkg::OP_ANDI:  expAluOp = mipsCtrlPkg::ALU_AND;
      mipsCtrlPkg::OP_ORI:   expAluOp = mipsCtrlPkg::ALU_OR;
      mipsCtrlPkg::OP_XORI:  expAluOp = mipsCtrlPkg::ALU_XOR;
      mipsCtrlPkg::OP_LUI:   expAluOp = mipsCtrlPkg::ALU_LUI;
      mipsCtrlPkg::OP_J:     expAluOp = mipsCtrlPkg::ALU_JTARGET;
      mipsCtrlPkg::OP_BEQ,
      mipsCtrlPkg::OP_BNE: begin
        expAluOp = mipsCtrlPkg::ALU_CMPEQ;
        expTaken = (op == mipsCtrlPkg::OP_BEQ) ? aluFlag : !aluFlag;
      end
      mipsCtrlPkg::OP_BLEZ,
      mipsCtrlPkg::OP_BGTZ: begin
        expAluOp = mipsCtrlPkg::ALU_CMPZ;
        expTaken = (op == mipsCtrlPkg::OP_BLEZ) ? aluFlag : !aluFlag;
      end
      mipsCtrlPkg::OP_REGIMM: begin
        expAluOp = mipsCtrlPkg::ALU_CMPZ;
        expTaken = (rt == mipsCtrlPkg::RT_BLTZ) ? lessThan : !lessThan;
      end
      mipsCtrlPkg::OP_LH: begin
        expEnable = 4'b0011;
        expExtend = 2'b11;
      end
      mipsCtrlPkg::OP_LHU: expEnable = 4'b0011;
      mipsCtrlPkg::OP_LB: begin
        expEnable = 4'b0001;
        expExtend = 2'b10;
      end
      mipsCtrlPkg::OP_LBU: expEnable = 4'b0001;
      default: ;
    endcase
  end

  always_comb begin
    case (state)
      mipsCtrlPkg::ST_HALTED: expNext = start ? mipsCtrlPkg::ST_FETCH : mipsCtrlPkg::ST_HALTED;
      mipsCtrlPkg::ST_FETCH,
      mipsCtrlPkg::ST_STALL:  expNext = waitrequest ? mipsCtrlPkg::ST_STALL :
                                                      mipsCtrlPkg::ST_DECODE;
      mipsCtrlPkg::ST_DECODE: expNext = mipsCtrlPkg::ST_EXEC1;
      mipsCtrlPkg::ST_EXEC1:  expNext = stall ? mipsCtrlPkg::ST_EXEC1 :
                              (isAluReg || isAluImm || isLoad || isStore) ?
                              mipsCtrlPkg::ST_EXEC2 : mipsCtrlPkg::ST_FETCH;
      mipsCtrlPkg::ST_EXEC2:  expNext = waitrequest ? mipsCtrlPkg::ST_EXEC2 :
                              isLoad ? mipsCtrlPkg::ST_EXEC3 : mipsCtrlPkg::ST_FETCH;
      default:                expNext = mipsCtrlPkg::ST_FETCH;
    endcase
    if (pcIsZero && (state != mipsCtrlPkg::ST_HALTED)) begin
      expNext = mipsCtrlPkg::ST_HALTED;
    end
  end

  // Expected values from the previous edge
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      prevExpNext <= mipsCtrlPkg::ST_HALTED;
      prevTaken <= 1'b0;
    end else begin
      prevExpNext <= expNext;
      prevTaken <= expTaken;
    end
  end

  assert property (@(posedge clk) !rstN |-> (state == mipsCtrlPkg::ST_HALTED) && !active &&
    !pcWrite && !irWrite && !memRead && !memWrite && !regWrite)
    else reportViolation("outputs not idle during reset");
  assert property (@(posedge clk) disable iff (!rstN)
    (state == mipsCtrlPkg::ST_HALTED) && start |=> state == mipsCtrlPkg::ST_FETCH)
    else reportViolation("start in HALTED did not reach FETCH");
  assert property (@(posedge clk) disable iff (!rstN)
    (state != mipsCtrlPkg::ST_HALTED) && pcIsZero |=> state == mipsCtrlPkg::ST_HALTED)
    else reportViolation("zero PC did not halt the unit");
  assert property (@(posedge clk) disable iff (!rstN) 1'b1 |=> state == prevExpNext)
    else reportViolation($sformatf("[FAIL] state %0d expected %0d", state, prevExpNext));
  assert property (@(posedge clk) disable iff (!rstN)
    pcWrite |-> state == mipsCtrlPkg::ST_FETCH)
    else reportViolation("pcWrite outside FETCH");
  assert property (@(posedge clk) disable iff (!rstN)
    irWrite |-> state == mipsCtrlPkg::ST_DECODE)
    else reportViolation("irWrite outside DECODE");
  assert property (@(posedge clk) disable iff (!rstN)
    state == mipsCtrlPkg::ST_FETCH |-> memRead && (byteEnable == 4'b1111) &&
    (pcSrc == branchPending))
    else reportViolation("fetch request or PC source wrong");
  assert property (@(posedge clk) disable iff (!rstN)
    (state == mipsCtrlPkg::ST_FETCH) && !branchPending |->
    (aluControl == mipsCtrlPkg::ALU_ADD) && (aluSrcB == 2'b01))
    else reportViolation("PC plus 4 controls wrong in FETCH");
  assert property (@(posedge clk) disable iff (!rstN)
    state == mipsCtrlPkg::ST_DECODE |->
    aluControl == (isJ ? mipsCtrlPkg::ALU_PASSB : mipsCtrlPkg::ALU_BRTARGET))
    else reportViolation("aluControl wrong in DECODE");
  assert property (@(posedge clk) disable iff (!rstN)
    ((state == mipsCtrlPkg::ST_FETCH) || (state == mipsCtrlPkg::ST_STALL)) &&
    !waitrequest && !pcIsZero |=> !branchPending)
    else reportViolation("branchPending not cleared on entering DECODE");
  assert property (@(posedge clk) disable iff (!rstN)
    (state == mipsCtrlPkg::ST_EXEC2) && isLoad |-> memRead && iOrD &&
    (byteEnable == expEnable) && (extendMode == expExtend))
    else reportViolation("load access controls wrong in EXEC2");
  assert property (@(posedge clk) disable iff (!rstN)
    state == mipsCtrlPkg::ST_EXEC3 |-> isLoad && regWrite && !memToReg)
    else reportViolation("EXEC3 write-back wrong");
  assert property (@(posedge clk) disable iff (!rstN)
    memWrite |-> (state == mipsCtrlPkg::ST_EXEC2) && isStore && (byteEnable == 4'b1111))
    else reportViolation("memWrite outside EXEC2 of SW");
  assert property (@(posedge clk) disable iff (!rstN)
    isStore && (state != mipsCtrlPkg::ST_HALTED) |-> !regWrite)
    else reportViolation("register write during SW");
  assert property (@(posedge clk) disable iff (!rstN)
    (state == mipsCtrlPkg::ST_EXEC1) && known |-> aluControl == expAluOp)
    else reportViolation($sformatf("[FAIL] aluControl %0d expected %0d",
      aluControl, expAluOp));
  assert property (@(posedge clk) disable iff (!rstN)
    (state == mipsCtrlPkg::ST_EXEC2) && (isAluReg || isAluImm) |-> regWrite &&
    (regDst == isAluReg))
    else reportViolation("ALU write-back controls wrong in EXEC2");
  assert property (@(posedge clk) disable iff (!rstN)
    (state == mipsCtrlPkg::ST_EXEC1) && !stall && !pcIsZero && (isBranch || isJ || isJr)
    |=> branchPending == prevTaken)
    else reportViolation($sformatf("[FAIL] branchPending %0b expected %0b",
      branchPending, prevTaken));
  assert property (@(posedge clk) disable iff (!rstN)
    isJump == ((state == mipsCtrlPkg::ST_EXEC1) && isJ))
    else reportViolation("isJump outside EXEC1 of J");

endmodule

bind controlTop ctrlChecker checkerI (.*);

`default_nettype wire

/* verif/controlTb.sv */
`default_nettype none

module controlTb;

  timeunit 1ns;
  timeprecision 100ps;

  logic clk;
  logic rstN;
  logic [31:0] instr;
  logic stall;
  logic waitrequest;
  logic pcIsZero;
  logic start;
  logic aluFlag;
  logic lessThan;
  mipsCtrlPkg::ctrlState_t state;
  logic branchPending;
  logic active;
  logic pcWrite;
  logic irWrite;
  logic regWrite;
  logic memRead;
  logic memWrite;
  logic irSel;
  logic iOrD;
  logic pcSrc;
  logic aluSrcA;
  logic aluSel;
  logic regDst;
  logic memToReg;
  logic extSel;
  logic [1:0] aluSrcB;
  mipsCtrlPkg::aluOp_t aluControl;
  logic [3:0] byteEnable;
  logic [1:0] extendMode;
  logic isJump;

  logic [5:0] opcodeTable [17] = '{
    mipsCtrlPkg::OP_ADDIU, mipsCtrlPkg::OP_SLTI, mipsCtrlPkg::OP_ANDI, mipsCtrlPkg::OP_ORI,
    mipsCtrlPkg::OP_XORI, mipsCtrlPkg::OP_LUI, mipsCtrlPkg::OP_LB, mipsCtrlPkg::OP_LH,
    mipsCtrlPkg::OP_LW, mipsCtrlPkg::OP_LBU, mipsCtrlPkg::OP_LHU, mipsCtrlPkg::OP_SW,
    mipsCtrlPkg::OP_BEQ, mipsCtrlPkg::OP_BNE, mipsCtrlPkg::OP_BLEZ, mipsCtrlPkg::OP_BGTZ,
    mipsCtrlPkg::OP_J
  };
  logic [5:0] functTable [4] = '{
    mipsCtrlPkg::FN_ADDU, mipsCtrlPkg::FN_AND, mipsCtrlPkg::FN_OR, mipsCtrlPkg::FN_JR
  };

  controlTop dut_i (.*);

  always #5 clk = ~clk;

  always @(dut_i.checkerI.failCount) begin
    if (dut_i.checkerI.failCount != 0) begin
      $display("TEST FAIL");
      $fatal(1, "checker assertion failed at %0t", $time);
    end
  end

  task automatic advanceCycle();
    @(posedge clk);
    #1;
  endtask

  task automatic waitForState(input mipsCtrlPkg::ctrlState_t target, input int limit,
                              input string what);
    int cycles;
    cycles = 0;
    while (state != target) begin
      if (cycles >= limit) begin
        $display("TEST FAIL");
        $fatal(1, "timeout waiting for %s", what);
      end else begin
        advanceCycle();
        cycles++;
      end
    end
  endtask

  // Mostly kept instructions, some R-type and fully random words for INVALID
  function automatic logic [31:0] pickInstruction();
    logic [31:0] word;
    int unsigned choice;
    word = $urandom;
    choice = $urandom % 10;
    if (choice < 5) begin
      word[31:26] = opcodeTable[5'($urandom % 17)];
    end else if (choice < 7) begin
      word[31:26] = mipsCtrlPkg::OP_RTYPE;
      word[5:0] = functTable[2'($urandom)];
    end else if (choice < 8) begin
      word[31:26] = mipsCtrlPkg::OP_REGIMM;
      word[20:16] = 5'($urandom % 2);
    end else if (choice < 9) begin
      word[31:26] = mipsCtrlPkg::OP_RTYPE;
    end
    return word;
  endfunction

  // Runs one instruction from FETCH back to the next FETCH
  task automatic runInstruction(input logic [31:0] word);
    int cycles;
    logic leftFetch;
    cycles = 0;
    leftFetch = 1'b0;
    instr = word;
    while (!leftFetch || (state != mipsCtrlPkg::ST_FETCH)) begin
      if (cycles >= 60) begin
        $display("TEST FAIL");
        $fatal(1, "timeout: instruction %h did not complete", word);
      end else begin
        waitrequest = (($urandom % 3) == 0);
        stall = (($urandom % 4) == 0);
        aluFlag = 1'($urandom);
        lessThan = 1'($urandom);
        advanceCycle();
        cycles++;
        if (state != mipsCtrlPkg::ST_FETCH) begin
          leftFetch = 1'b1;
        end
      end
    end
  endtask

  task automatic haltAndRestart();
    instr = pickInstruction();
    repeat (2 + $urandom % 3) advanceCycle();
    pcIsZero = 1'b1;
    advanceCycle();
    pcIsZero = 1'b0;
    waitForState(mipsCtrlPkg::ST_HALTED, 4, "HALTED after zero PC");
    repeat (2) advanceCycle();
    start = 1'b1;
    advanceCycle();
    start = 1'b0;
    waitForState(mipsCtrlPkg::ST_FETCH, 4, "FETCH after restart");
  endtask

  initial begin
    void'($urandom(65));
    clk = 1'b0;
    rstN = 1'b1;
    instr = '0;
    stall = 1'b0;
    waitrequest = 1'b0;
    pcIsZero = 1'b0;
    start = 1'b0;
    aluFlag = 1'b0;
    lessThan = 1'b0;
    #1 rstN = 1'b0;
    repeat (4) @(posedge clk);
    #1 rstN = 1'b1;
    repeat (3) advanceCycle();
    start = 1'b1;
    advanceCycle();
    start = 1'b0;
    waitForState(mipsCtrlPkg::ST_FETCH, 4, "first FETCH");
    for (int n = 0; n < 400; n++) begin
      runInstruction(pickInstruction());
      if ((n % 50) == 49) begin
        haltAndRestart();
      end
    end
    repeat (2) advanceCycle();
    if (dut_i.checkerI.failCount == 0) begin
      $display("TEST PASS");
      $finish;
    end else begin
      $display("TEST FAIL");
      $fatal(1, "checker recorded %0d failures", dut_i.checkerI.failCount);
    end
  end

endmodule

`default_nettype wire

/* flist.f */
rtl/mipsCtrlPkg.sv
rtl/decodedIf.sv
rtl/instrClassifier.sv
rtl/stateSequencer.sv
rtl/stepControl.sv
rtl/controlTop.sv
verif/ctrl_checker.sv
verif/controlTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= controlTb
FLIST ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert --timescale 1ns/100ps
SIM_ARGS ?= +verilator+error+limit+100

SOURCES := $(shell grep -v '^+' $(FLIST))
SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

$(SIM): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR) -o V$(TOP)

# Exit status comes from grep, so a missing pass line fails the target
run: $(SIM)
	$(SIM) $(SIM_ARGS) | tee /dev/stderr | grep -qx 'TEST PASS'

clean:
	rm -rf $(BUILD_DIR)
